//--- list.f
+incdir+include
rtl/gb_map_pkg.sv
rtl/gb_ctrl_pkg.sv
rtl/gb_bus_ifs.sv
rtl/gb_bus_arbiter.sv
rtl/gb_mem_system.sv
rtl/gb_oam_dma.sv
rtl/gb_io_regs.sv
rtl/gb_core_top.sv
bench/tb_gb_core.sv

//--- run_sim.sh
#!/bin/bash
# compile and run the testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gb_core -Mdir obj_dir -f list.f

./obj_dir/Vtb_gb_core | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- bench/tb_gb_core.sv
module tb_gb_core import gb_map_pkg::*, gb_ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned MAX_CYCLES = 20000;  // all tests need about 3k cycles
	localparam int unsigned DMA_CYCLES = 320;    // 160 read and write pairs
	localparam int unsigned SEED       = 32'h50c8_1311;

	logic       clk_sys;
	logic       reset_ss;
	cpu_addr_t  paddr_i;
	logic       psel_i;
	logic       penable_i;
	logic       pwrite_i;
	data_t      pwdata_i;
	data_t      prdata_o;
	logic       pready_o;
	cpu_addr_t  cart_addr_o;
	logic       cart_rd_o;
	logic       cart_wr_o;
	data_t      cart_wdata_o;
	data_t      cart_rdata_i;
	logic       cart_oe_i;
	logic [3:0] joy_din_i;
	logic [1:0] joy_sel_o;
	logic [3:0] irq_events_i;
	logic       irq_ack_i;
	logic       irq_pending_o;
	irq_vec_t   irq_vector_o;
	logic       dma_active_o;

	logic       rd_check;      // compare prdata on the completing read
	data_t      rd_expect;
	logic       irq_check;
	logic       exp_pending;
	irq_vec_t   exp_vector;
	logic       mem_target;    // address sits behind the shared bus
	data_t      bank_byte [8];
	data_t      src_byte [160];
	data_t      hram_byte [7];
	data_t      echo_byte;
	int         cycle_cnt    = 0;
	int         dma_len      = 0;
	int         stall_cycles = 0;
	int         cart_rd_cnt  = 0;
	int         cart_wr_cnt  = 0;

	gb_core_top uut (.*);

	// --------------------------------------------------
	// clock and cartridge model
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic data_t cart_byte(input cpu_addr_t addr);
		return addr[7:0] ^ 8'hA5;
	endfunction

	assign cart_rdata_i = cart_byte(cart_addr_o);
	assign cart_oe_i    = cart_addr_o[15:13] != 3'b101;  // no cart ram fitted
	// a000-fe9f is cart ram, wram, echo and oam in one run
	assign mem_target = paddr_i < 16'h8000 || (paddr_i >= 16'hA000 && paddr_i < 16'hFEA0) ||
		paddr_i == 16'hFF70;

	// --------------------------------------------------
	// failure reporting
	task automatic report_mismatch(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	// --------------------------------------------------
	// apb master
	task automatic transfer(input cpu_addr_t addr, input logic wr, input data_t data);
		@(posedge clk_sys);
		psel_i    <= 1'b1;  // setup
		penable_i <= 1'b0;
		pwrite_i  <= wr;
		paddr_i   <= addr;
		pwdata_i  <= data;
		@(posedge clk_sys);
		penable_i <= 1'b1;
		@(negedge clk_sys);
		while (!pready_o)
			@(negedge clk_sys);  // held off by dma
		@(posedge clk_sys);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic write_reg(input cpu_addr_t addr, input data_t data);
		transfer(addr, 1'b1, data);
	endtask

	task automatic read_expect(input cpu_addr_t addr, input data_t exp);
		rd_expect <= exp;
		rd_check  <= 1'b1;
		transfer(addr, 1'b0, 8'h00);
		rd_check  <= 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic expect_irq(input logic pending, input irq_vec_t vector);
		exp_pending <= pending;
		exp_vector  <= vector;
		irq_check   <= 1'b1;
		wait_cycles(2);
		irq_check   <= 1'b0;
	endtask

	task automatic pulse_ack();
		irq_ack_i <= 1'b1;
		@(posedge clk_sys);
		irq_ack_i <= 1'b0;
		wait_cycles(3);  // clears on the falling ack
	endtask

	// --------------------------------------------------
	// monitors and timeout
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		dma_len   <= dma_active_o ? dma_len + 1 : 0;
		if (cart_rd_o)
			cart_rd_cnt <= cart_rd_cnt + 1;
		if (cart_wr_o)
			cart_wr_cnt <= cart_wr_cnt + 1;
		if (psel_i && penable_i && dma_active_o && mem_target && !pready_o)
			stall_cycles <= stall_cycles + 1;
	end

	always @(posedge clk_sys) begin
		if (cycle_cnt == MAX_CYCLES)
			abort_run("Timeout: the test did not finish within the cycle limit");
	end

	// --------------------------------------------------
	// checks
	a_reset: assert property (@(posedge clk_sys) $fell(reset_ss) |->
		!(pready_o || cart_rd_o || cart_wr_o || irq_pending_o || dma_active_o))
		else report_mismatch("outputs not low after reset");

	a_rdata: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(psel_i && penable_i && pready_o && !pwrite_i && rd_check) |-> prdata_o == rd_expect)
		else report_mismatch($sformatf("read %h gave %h, expected %h",
			$sampled(paddr_i), $sampled(prdata_o), $sampled(rd_expect)));

	a_joy_sel: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(psel_i && penable_i && pready_o && rd_check && paddr_i == 16'hFF00) |->
		joy_sel_o == rd_expect[5:4])
		else report_mismatch("joy_sel_o differs from the select bits");

	a_irq: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_check |-> (irq_pending_o == exp_pending && irq_vector_o == exp_vector))
		else report_mismatch($sformatf("irq pending %b vector %h, expected %b %h",
			$sampled(irq_pending_o), $sampled(irq_vector_o),
			$sampled(exp_pending), $sampled(exp_vector)));

	a_dma_start: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(psel_i && penable_i && pready_o && pwrite_i && paddr_i == 16'hFF46) |-> dma_active_o)
		else report_mismatch("dma_active_o not high after the FF46 write");

	a_dma_len: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$fell(dma_active_o) |-> dma_len == DMA_CYCLES)
		else report_mismatch($sformatf("dma ran %0d cycles", $sampled(dma_len)));

	a_dma_stall: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(psel_i && penable_i && dma_active_o && mem_target) |-> !pready_o)
		else report_mismatch("memory access completed during dma");

	// one free cycle to take the request, then ready
	a_dma_release: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(psel_i && penable_i && mem_target && $past(dma_active_o, 2) && !$past(dma_active_o))
		|-> pready_o)
		else report_mismatch("stalled access not released after dma");

	a_cart_addr: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(cart_rd_o || cart_wr_o) |-> (cart_addr_o == paddr_i && cart_wr_o == pwrite_i))
		else report_mismatch($sformatf("cart strobe at %h", $sampled(cart_addr_o)));

	a_cart_wdata: assert property (@(posedge clk_sys) disable iff (reset_ss)
		cart_wr_o |-> cart_wdata_o == pwdata_i)
		else report_mismatch("cart_wdata_o differs from the written byte");

	a_cart_pulse: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(cart_rd_o || cart_wr_o) |-> !$past(cart_rd_o || cart_wr_o))
		else report_mismatch("cart strobe longer than one cycle");

	// --------------------------------------------------
	// stimulus
	initial begin
		reset_ss     = 1'b1;
		paddr_i      = '0;
		psel_i       = 1'b0;
		penable_i    = 1'b0;
		pwrite_i     = 1'b0;
		pwdata_i     = '0;
		joy_din_i    = 4'hF;  // released
		irq_events_i = '0;
		irq_ack_i    = 1'b0;
		rd_check     = 1'b0;
		rd_expect    = '0;
		irq_check    = 1'b0;
		exp_pending  = 1'b0;
		exp_vector   = '0;
		void'($urandom(SEED));
		wait_cycles(10);
		reset_ss <= 1'b0;
		wait_cycles(2);

		// work ram banks, low bits tag the bank so no two bytes match
		for (int b = 1; b < 8; b++) begin
			bank_byte[b] = {5'($urandom), 3'(b)};
			write_reg(16'hFF70, data_t'(b));
			write_reg(16'hD000, bank_byte[b]);
		end
		for (int b = 1; b < 8; b++) begin
			write_reg(16'hFF70, data_t'(b));
			read_expect(16'hD000, bank_byte[b]);
		end
		write_reg(16'hFF70, 8'h00);  // 0 means bank 1
		read_expect(16'hD000, bank_byte[1]);
		echo_byte = data_t'($urandom);
		write_reg(16'hC000, echo_byte);
		read_expect(16'hE000, echo_byte);

		// hram ff80 up to fffe
		for (int i = 0; i < 7; i++) begin
			hram_byte[i] = data_t'($urandom);
			write_reg(16'hFF80 + 16'(21 * i), hram_byte[i]);
		end
		for (int i = 0; i < 7; i++)
			read_expect(16'hFF80 + 16'(21 * i), hram_byte[i]);

		// joypad, ie, if
		joy_din_i <= 4'hA;
		write_reg(16'hFF00, 8'h2F);
		read_expect(16'hFF00, 8'hEA);
		write_reg(16'hFF00, 8'h10);
		read_expect(16'hFF00, 8'hDA);
		write_reg(16'hFFFF, 8'hA5);
		read_expect(16'hFFFF, 8'hA5);
		write_reg(16'hFF0F, 8'h0B);
		read_expect(16'hFF0F, 8'hEB);

		// interrupts from a clean state
		write_reg(16'hFFFF, 8'h00);
		write_reg(16'hFF0F, 8'h00);
		joy_din_i <= 4'hF;  // rising edge sets nothing
		wait_cycles(4);
		irq_events_i <= 4'b0110;  // lcd and timer
		@(posedge clk_sys);
		irq_events_i <= 4'b0000;
		joy_din_i    <= 4'hE;
		wait_cycles(5);
		read_expect(16'hFF0F, 8'hF6);
		expect_irq(1'b0, 8'h00);  // flags set, nothing enabled
		write_reg(16'hFFFF, 8'h14);
		expect_irq(1'b1, 8'h50);  // timer and joypad enabled
		pulse_ack();  // timer goes first
		read_expect(16'hFF0F, 8'hF2);
		expect_irq(1'b1, 8'h60);  // joypad left
		pulse_ack();
		read_expect(16'hFF0F, 8'hE2);
		expect_irq(1'b0, 8'h00);  // lcd still flagged but masked
		write_reg(16'hFFFF, 8'h1F);
		expect_irq(1'b1, 8'h48);
		irq_events_i <= 4'b0001;  // vblank outranks lcd
		@(posedge clk_sys);
		irq_events_i <= 4'b0000;
		wait_cycles(2);
		expect_irq(1'b1, 8'h40);

		// oam dma from page c3
		for (int i = 0; i < 160; i++) begin
			src_byte[i] = data_t'($urandom);
			write_reg(16'hC300 + 16'(i), src_byte[i]);
		end
		write_reg(16'hFF46, 8'hC3);
		read_expect(16'hFE50, src_byte[8'h50]);  // waits out the copy
		assert (stall_cycles > 0)
			else abort_run("The OAM read during the copy was never held off");
		for (int i = 0; i < 160; i++)
			read_expect(16'hFE00 + 16'(i), src_byte[i]);

		// cartridge and open bus
		read_expect(16'h1234, cart_byte(16'h1234));
		write_reg(16'h2000, 8'h05);
		read_expect(16'h4567, cart_byte(16'h4567));
		read_expect(16'hA010, cart_byte(16'h4567));  // last driven byte lingers
		wait_cycles(10);
		read_expect(16'hA010, 8'hFF);

		if (cart_rd_cnt == 4 && cart_wr_cnt == 1) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("Wrong number of cartridge read or write strobes");
		end
	end

endmodule

//--- rtl/gb_core_top.sv
module gb_core_top import gb_map_pkg::*, gb_ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	// apb slave
	input  cpu_addr_t  paddr_i,
	input  logic       psel_i,
	input  logic       penable_i,
	input  logic       pwrite_i,
	input  data_t      pwdata_i,
	output data_t      prdata_o,
	output logic       pready_o,
	// cartridge
	output cpu_addr_t  cart_addr_o,
	output logic       cart_rd_o,
	output logic       cart_wr_o,
	output data_t      cart_wdata_o,
	input  data_t      cart_rdata_i,
	input  logic       cart_oe_i,
	// joypad
	input  logic [3:0] joy_din_i,
	output logic [1:0] joy_sel_o,
	// interrupts
	input  logic [3:0] irq_events_i,  // vblank, lcd, timer, serial
	input  logic       irq_ack_i,
	output logic       irq_pending_o,
	output irq_vec_t   irq_vector_o,
	output logic       dma_active_o
);

	gb_mem_if dma_bus ();  // dma engine -> arbiter
	gb_mem_if mem_bus ();  // arbiter -> memories
	gb_reg_if io_bus ();

	logic  dma_start;
	data_t dma_page;

	// --------------------------------------------------
	gb_bus_arbiter u_arb (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.dma_bus     (dma_bus.slave),
		.mem_bus     (mem_bus.master),
		.io_bus      (io_bus.master),
		.dma_start_o (dma_start),
		.dma_page_o  (dma_page),
		.dma_busy_i  (dma_active_o)
	);

	gb_mem_system u_mem (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.mem_bus      (mem_bus.slave),
		.cart_addr_o  (cart_addr_o),
		.cart_rd_o    (cart_rd_o),
		.cart_wr_o    (cart_wr_o),
		.cart_wdata_o (cart_wdata_o),
		.cart_rdata_i (cart_rdata_i),
		.cart_oe_i    (cart_oe_i)
	);

	gb_oam_dma u_dma (
		.clk_sys  (clk_sys),
		.reset_ss (reset_ss),
		.start_i  (dma_start),
		.page_i   (dma_page),
		.busy_o   (dma_active_o),
		.dma_bus  (dma_bus.master)
	);

	gb_io_regs u_io (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.io_bus        (io_bus.slave),
		.joy_din_i     (joy_din_i),
		.joy_sel_o     (joy_sel_o),
		.irq_events_i  (irq_events_i),
		.irq_ack_i     (irq_ack_i),
		.irq_pending_o (irq_pending_o),
		.irq_vector_o  (irq_vector_o)
	);

endmodule

//--- rtl/gb_io_regs.sv
`include "gb_cfg.svh"

module gb_io_regs import gb_map_pkg::*, gb_ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	gb_reg_if.slave    io_bus,
	input  logic [3:0] joy_din_i,
	output logic [1:0] joy_sel_o,      // p15/p14
	input  logic [3:0] irq_events_i,
	input  logic       irq_ack_i,
	output logic       irq_pending_o,
	output irq_vec_t   irq_vector_o
);

	localparam data_t JOYP_A = data_t'(`GB_ADDR_JOYP);
	localparam data_t IF_A   = data_t'(`GB_ADDR_IF);
	localparam data_t IE_A   = data_t'(`GB_ADDR_IE);

	data_t      hram_mem [`GB_HRAM_LEN];
	hram_addr_t hram_idx;
	data_t      rdata_q;
	data_t      ie_q;
	irq_mask_t  if_q;
	irq_mask_t  pend;
	irq_mask_t  ack_clr;
	irq_mask_t  set_mask;
	irq_mask_t  if_base;
	logic [3:0] ev_q;
	logic [3:0] joy_s1;
	logic [3:0] joy_s2;
	logic       ack_q;
	logic       wr;
	logic       rd;
	logic       hram_sel;

	assign wr       = io_bus.req & io_bus.we;
	assign rd       = io_bus.req & ~io_bus.we;
	assign hram_sel = io_bus.addr[7] && io_bus.addr != IE_A;  // ff80-fffe
	assign hram_idx = hram_addr_t'(io_bus.addr);

	// --------------------------------------------------
	// hram and read data
	always_ff @(posedge clk_sys) begin
		if (wr && hram_sel)
			hram_mem[hram_idx] <= io_bus.wdata;
		if (rd) begin
			if (hram_sel)
				rdata_q <= hram_mem[hram_idx];
			else if (io_bus.addr == JOYP_A)
				rdata_q <= {2'b11, joy_sel_o, joy_din_i};
			else if (io_bus.addr == IF_A)
				rdata_q <= {3'b111, if_q};
			else
				rdata_q <= ie_q;
		end
	end

	assign io_bus.rdata = rdata_q;

	// --------------------------------------------------
	// interrupt flags
	assign pend     = irq_mask_t'(ie_q) & if_q;
	// falling ack drops the winning bit only
	assign ack_clr  = (ack_q & ~irq_ack_i) ? (pend & (~pend + irq_mask_t'(1))) : '0;
	assign set_mask = {|(joy_s2 & ~joy_s1), irq_events_i & ~ev_q};
	assign if_base  = (wr && io_bus.addr == IF_A) ? irq_mask_t'(io_bus.wdata) : if_q;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_q      <= '0;
			if_q      <= '0;
			joy_sel_o <= 2'b00;
			ev_q      <= '0;
			joy_s1    <= 4'hF;   // lines idle high
			joy_s2    <= 4'hF;
			ack_q     <= 1'b0;
		end else begin
			ev_q   <= irq_events_i;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			ack_q  <= irq_ack_i;
			if_q   <= (if_base & ~ack_clr) | set_mask;   // new events win over ack
			if (wr && io_bus.addr == IE_A)
				ie_q <= io_bus.wdata;
			if (wr && io_bus.addr == JOYP_A)
				joy_sel_o <= io_bus.wdata[5:4];
		end
	end

	assign irq_pending_o = |pend;

	// 40, 48, 50, 58, 60 by lowest pending bit
	always_comb begin
		irq_vector_o = '0;
		for (int i = `GB_IRQ_SRCS - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vector_o = `GB_IRQ_VEC_BASE + irq_vec_t'(i * `GB_IRQ_VEC_STEP);
		end
	end

endmodule

//--- rtl/gb_oam_dma.sv
`include "gb_cfg.svh"

module gb_oam_dma import gb_map_pkg::*, gb_ctrl_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset_ss,
	input  logic     start_i,
	input  data_t    page_i,   // source is page_i * 256
	output logic     busy_o,
	gb_mem_if.master dma_bus
);

	dma_state_e state_q;
	oam_addr_t  idx_q;
	data_t      page_q;
	cpu_addr_t  src_addr;
	logic       wr_phase;
	logic       last;

	assign src_addr = {page_q, idx_q};
	assign wr_phase = state_q == DMA_WRITE;
	assign last     = idx_q == oam_addr_t'(`GB_OAM_LEN - 1);
	assign busy_o   = state_q != DMA_IDLE;

	// --------------------------------------------------
	// bus request every cycle while busy
	assign dma_bus.req    = busy_o;
	assign dma_bus.we     = wr_phase;
	assign dma_bus.addr   = wr_phase ? {`GB_PAGE_OAM, idx_q} : src_addr;
	assign dma_bus.region = wr_phase ? REG_OAM : decode_region(src_addr);
	assign dma_bus.wdata  = dma_bus.rdata;   // byte from the read cycle

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state_q <= DMA_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				DMA_IDLE: begin
					if (start_i) begin
						state_q <= DMA_READ;
						idx_q   <= '0;
					end
				end
				DMA_READ: state_q <= DMA_WRITE;
				DMA_WRITE: begin
					if (last) begin
						state_q <= DMA_IDLE;   // 160 bytes done
					end else begin
						idx_q   <= idx_q + 1'b1;
						state_q <= DMA_READ;
					end
				end
				default: state_q <= DMA_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_i && state_q == DMA_IDLE)
			page_q <= page_i;
	end

endmodule

//--- rtl/gb_mem_system.sv
`include "gb_cfg.svh"

module gb_mem_system import gb_map_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset_ss,
	gb_mem_if.slave   mem_bus,
	output cpu_addr_t cart_addr_o,
	output logic      cart_rd_o,
	output logic      cart_wr_o,
	output data_t     cart_wdata_o,
	input  data_t     cart_rdata_i,
	input  logic      cart_oe_i
);

	localparam int unsigned WRAM_DEPTH = `GB_WRAM_BANKS * `GB_WRAM_BANK_BYTES;
	localparam int unsigned DECAY_W    = $clog2(`GB_OPEN_BUS_DECAY + 1);

	data_t      wram_mem [WRAM_DEPTH];
	data_t      oam_mem [`GB_OAM_LEN];
	wram_bank_t bank_q;       // svbk
	wram_bank_t svbk_val;
	wram_addr_t wram_idx;
	oam_addr_t  oam_idx;
	data_t      wram_q;
	data_t      oam_q;
	data_t      cart_q;
	data_t      open_bus_q;   // last byte the cart drove
	logic [DECAY_W-1:0] decay_q;
	region_e    rsel_q;
	logic       wram_sel;
	logic       oam_sel;
	logic       cart_sel;
	logic       cart_drive;

	assign wram_sel = mem_bus.req && mem_bus.region == REG_WRAM;
	assign oam_sel  = mem_bus.req && mem_bus.region == REG_OAM;
	assign cart_sel = mem_bus.req && mem_bus.region == REG_CART;

	// c000-cfff is bank 0, d000-dfff the selected bank
	assign wram_idx = {(mem_bus.addr[12] ? bank_q : wram_bank_t'(0)), mem_bus.addr[11:0]};
	assign oam_idx  = mem_bus.addr[7:0];

	// --------------------------------------------------
	// bank register, 0 selects bank 1
	assign svbk_val = wram_bank_t'(mem_bus.wdata);

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			bank_q <= wram_bank_t'(1);
		end else if (mem_bus.req && mem_bus.we && mem_bus.region == REG_SVBK) begin
			bank_q <= (svbk_val == '0) ? wram_bank_t'(1) : svbk_val;
		end
	end

	// --------------------------------------------------
	// memories and read registers
	always_ff @(posedge clk_sys) begin
		if (wram_sel) begin
			if (mem_bus.we)
				wram_mem[wram_idx] <= mem_bus.wdata;
			wram_q <= wram_mem[wram_idx];
		end
		if (oam_sel) begin
			if (mem_bus.we)
				oam_mem[oam_idx] <= mem_bus.wdata;
			oam_q <= oam_mem[oam_idx];
		end
		if (cart_rd_o)
			cart_q <= cart_oe_i ? cart_rdata_i : open_bus_q;  // undriven reads see the latch
	end

	// --------------------------------------------------
	// cartridge strobes, one cycle per taken request
	assign cart_rd_o    = cart_sel & ~mem_bus.we;
	assign cart_wr_o    = cart_sel & mem_bus.we;
	assign cart_addr_o  = mem_bus.addr;
	assign cart_wdata_o = mem_bus.wdata;
	assign cart_drive   = cart_rd_o & cart_oe_i;

	// open bus holds the byte a while then the pull-ups win
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			open_bus_q <= `GB_OPEN_BUS_IDLE;
			decay_q    <= DECAY_W'(`GB_OPEN_BUS_DECAY);
		end else if (cart_drive) begin
			open_bus_q <= cart_rdata_i;
			decay_q    <= '0;
		end else if (decay_q != DECAY_W'(`GB_OPEN_BUS_DECAY)) begin
			decay_q <= decay_q + 1'b1;   // saturates
			if (decay_q == DECAY_W'(`GB_OPEN_BUS_DECAY - 1))
				open_bus_q <= `GB_OPEN_BUS_IDLE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			rsel_q <= REG_NONE;
		else
			rsel_q <= (mem_bus.req && !mem_bus.we) ? mem_bus.region : REG_NONE;
	end

	always_comb begin
		case (rsel_q)
			REG_WRAM: mem_bus.rdata = wram_q;
			REG_OAM:  mem_bus.rdata = oam_q;
			REG_CART: mem_bus.rdata = cart_q;
			REG_SVBK: mem_bus.rdata = {5'h1F, bank_q};  // unused bits read high
			default:  mem_bus.rdata = `GB_OPEN_BUS_IDLE;
		endcase
	end

endmodule

//--- rtl/gb_bus_arbiter.sv
`include "gb_cfg.svh"

module gb_bus_arbiter import gb_map_pkg::*, gb_ctrl_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset_ss,
	input  cpu_addr_t paddr_i,
	input  logic      psel_i,
	input  logic      penable_i,
	input  logic      pwrite_i,
	input  data_t     pwdata_i,
	output data_t     prdata_o,
	output logic      pready_o,
	gb_mem_if.slave   dma_bus,
	gb_mem_if.master  mem_bus,
	gb_reg_if.master  io_bus,
	output logic      dma_start_o,
	output data_t     dma_page_o,
	input  logic      dma_busy_i
);

	region_e   cpu_region;
	region_e   src_region;
	region_e   rsp_region_q;   // target of the last cpu request
	cpu_addr_t src_addr;
	owner_e    owner;
	owner_e    owner_q;        // owner of the request now answering
	logic      cpu_mem;
	logic      cpu_req;
	logic      cpu_take;

	// --------------------------------------------------
	// cpu side decode
	assign cpu_region = decode_region(paddr_i);
	assign cpu_mem    = cpu_region inside {REG_CART, REG_WRAM, REG_OAM, REG_SVBK};

	// an access phase already answered must not fire again
	assign cpu_req  = psel_i & ~(penable_i & pready_o);
	assign cpu_take = cpu_req & ~(cpu_mem & dma_bus.req);  // dma wins the shared bus

	// --------------------------------------------------
	// shared memory bus
	assign owner      = dma_bus.req ? OWN_DMA : OWN_CPU;
	assign src_addr   = (owner == OWN_DMA) ? dma_bus.addr : paddr_i;
	assign src_region = (owner == OWN_DMA) ? dma_bus.region : cpu_region;

	assign mem_bus.req    = dma_bus.req | (cpu_take & cpu_mem);
	assign mem_bus.we     = (owner == OWN_DMA) ? dma_bus.we : pwrite_i;
	assign mem_bus.wdata  = (owner == OWN_DMA) ? dma_bus.wdata : pwdata_i;
	assign mem_bus.region = src_region;
	// echo e000-fdff folds onto c000-ddff
	assign mem_bus.addr = (src_region == REG_WRAM && src_addr[15:8] >= `GB_PAGE_ECHO) ?
		src_addr - `GB_ECHO_OFFSET : src_addr;

	assign dma_bus.rdata = (owner_q == OWN_DMA) ? mem_bus.rdata : `GB_OPEN_BUS_IDLE;

	// io registers never wait
	assign io_bus.req   = cpu_take & (cpu_region == REG_IO);
	assign io_bus.we    = pwrite_i;
	assign io_bus.addr  = paddr_i[7:0];
	assign io_bus.wdata = pwdata_i;

	// ff46 is write only, kicks the copy
	assign dma_start_o = cpu_take & pwrite_i & (paddr_i == `GB_ADDR_DMA) & ~dma_busy_i;
	assign dma_page_o  = pwdata_i;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			pready_o     <= 1'b0;
			owner_q      <= OWN_CPU;
			rsp_region_q <= REG_NONE;
		end else begin
			pready_o <= cpu_take;   // answer in the next access cycle
			owner_q  <= owner;
			if (cpu_take)
				rsp_region_q <= cpu_region;
		end
	end

	// read mux back to apb
	always_comb begin
		case (rsp_region_q)
			REG_IO:   prdata_o = io_bus.rdata;
			REG_NONE: prdata_o = `GB_OPEN_BUS_IDLE;
			default:  prdata_o = mem_bus.rdata;
		endcase
	end

endmodule

//--- rtl/gb_bus_ifs.sv
// shared memory bus, read data one cycle after the request
interface gb_mem_if import gb_map_pkg::*; ();
	logic      req;
	logic      we;
	cpu_addr_t addr;
	region_e   region;  // decoded by the master
	data_t     wdata;
	data_t     rdata;

	modport master (output req, we, addr, region, wdata, input rdata);
	modport slave  (input req, we, addr, region, wdata, output rdata);
endinterface

// register bus into the io block, only the low address byte
interface gb_reg_if import gb_map_pkg::*; ();
	logic  req;
	logic  we;
	data_t addr;
	data_t wdata;
	data_t rdata;

	modport master (output req, we, addr, wdata, input rdata);
	modport slave  (input req, we, addr, wdata, output rdata);
endinterface

//--- rtl/gb_ctrl_pkg.sv
package gb_ctrl_pkg;

`include "gb_cfg.svh"

	// bit 0 vblank ... bit 4 joypad, lowest bit wins
	typedef logic [`GB_IRQ_SRCS-1:0] irq_mask_t;
	typedef logic [7:0]              irq_vec_t;

	// oam dma alternates one read and one write per byte
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_e;

	// who drives the shared memory bus
	typedef enum logic {
		OWN_CPU,
		OWN_DMA
	} owner_e;

endpackage

//--- rtl/gb_map_pkg.sv
package gb_map_pkg;

`include "gb_cfg.svh"

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [$clog2(`GB_WRAM_BANKS * `GB_WRAM_BANK_BYTES)-1:0] wram_addr_t;
	typedef logic [$clog2(`GB_OAM_LEN)-1:0]    oam_addr_t;
	typedef logic [$clog2(`GB_HRAM_LEN)-1:0]   hram_addr_t;
	typedef logic [$clog2(`GB_WRAM_BANKS)-1:0] wram_bank_t;

	typedef enum logic [2:0] {
		REG_CART,  // rom and cart ram
		REG_WRAM,  // work ram incl echo
		REG_OAM,
		REG_SVBK,
		REG_IO,    // joyp, if, hram, ie
		REG_NONE   // floats high
	} region_e;

	// shared by the cpu side and the dma source
	function automatic region_e decode_region(input cpu_addr_t addr);
		data_t   pg;
		region_e rg;
		pg = addr[15:8];
		if (pg < `GB_PAGE_VRAM)
			rg = REG_CART;
		else if (pg < `GB_PAGE_CRAM)
			rg = REG_NONE;    // no vram in this core
		else if (pg < `GB_PAGE_WRAM)
			rg = REG_CART;    // a000-bfff cart ram
		else if (pg < `GB_PAGE_OAM)
			rg = REG_WRAM;    // c000-fdff
		else if (pg == `GB_PAGE_OAM)
			rg = (addr[7:0] < `GB_OAM_LEN) ? REG_OAM : REG_NONE;
		else if (addr == `GB_ADDR_SVBK)
			rg = REG_SVBK;
		else if (addr == `GB_ADDR_JOYP || addr == `GB_ADDR_IF || addr[7])
			rg = REG_IO;      // ff80-ffff holds hram and ie
		else
			rg = REG_NONE;
		return rg;
	endfunction

endpackage

//--- include/gb_cfg.svh
`ifndef GB_CFG_SVH
`define GB_CFG_SVH

// ram sizes
`define GB_WRAM_BANKS       8
`define GB_WRAM_BANK_BYTES  4096
`define GB_OAM_LEN          160
`define GB_HRAM_LEN         127

// cart bus pull-up after this many undriven cycles
`define GB_OPEN_BUS_DECAY   5
`define GB_OPEN_BUS_IDLE    8'hFF

// region boundary pages
`define GB_PAGE_VRAM        8'h80
`define GB_PAGE_CRAM        8'hA0
`define GB_PAGE_WRAM        8'hC0
`define GB_PAGE_ECHO        8'hE0
`define GB_PAGE_OAM         8'hFE
`define GB_ECHO_OFFSET      16'h2000

// register addresses
`define GB_ADDR_JOYP        16'hFF00
`define GB_ADDR_IF          16'hFF0F
`define GB_ADDR_DMA         16'hFF46
`define GB_ADDR_SVBK        16'hFF70
`define GB_ADDR_IE          16'hFFFF

// interrupt sources and rst vectors
`define GB_IRQ_SRCS         5
`define GB_IRQ_VEC_BASE     8'h40
`define GB_IRQ_VEC_STEP     8

`endif
